// File: verilog/axi_mem_pkg.sv
// ####################################################################
// AXI to memory bridge package.
// Bus widths, outstanding request depth and AXI response codes shared
// by the sequencer, the response buffer and the response composer.
// ####################################################################

package axi_mem_pkg;

  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int ID_W      = 4;
  localparam int LEN_W     = 8;
  localparam int SIZE_W    = 3;
  localparam int QOS_W     = 4;

  // Outstanding memory requests and the buffer pointer and count widths.
  localparam int BUF_DEPTH = 4;
  localparam int PTR_W     = $clog2(BUF_DEPTH);
  localparam int CNT_W     = $clog2(BUF_DEPTH + 1);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SIZE_W-1:0] size_t;
  typedef logic [QOS_W-1:0]  qos_t;
  typedef logic [1:0]        resp_t;

endpackage

// File: verilog/axi_burst_sequencer.sv
// ####################################################################
// AXI4 burst sequencer.
// Splits incrementing read and write bursts into single-word memory
// requests, arbitrates between the two directions by QoS and burst
// state, and reports every granted beat to the response buffer.
// ####################################################################

`timescale 1ns/1ps

module axi_burst_sequencer import axi_mem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  ar_valid_i,
  input  id_t   ar_id_i,
  input  addr_t ar_addr_i,
  input  len_t  ar_len_i,
  input  size_t ar_size_i,
  input  qos_t  ar_qos_i,
  output logic  ar_ready_o,
  input  logic  aw_valid_i,
  input  id_t   aw_id_i,
  input  addr_t aw_addr_i,
  input  len_t  aw_len_i,
  input  size_t aw_size_i,
  input  qos_t  aw_qos_i,
  output logic  aw_ready_o,
  input  logic  w_valid_i,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  output logic  w_ready_o,
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output strb_t mem_strb_o,
  output logic  mem_we_o,
  input  logic  mem_gnt_i,
  input  logic  full_i,
  output logic  alloc_o,
  output id_t   alloc_id_o,
  output logic  alloc_last_o,
  output logic  alloc_write_o
);

  // Remaining beats after the current one; nonzero means a burst is ongoing.
  len_t  r_cnt_q, w_cnt_q;
  addr_t r_addr_q, w_addr_q;
  id_t   r_id_q, w_id_q;
  size_t r_size_q, w_size_q;
  qos_t  r_qos_q, w_qos_q;
  logic  sel_q, lock_q;

  logic  r_ongoing, w_ongoing;
  logic  rd_valid, wr_valid, rd_last, wr_last;
  addr_t rd_addr, wr_addr;
  id_t   rd_id, wr_id;
  qos_t  rd_qos, wr_qos;
  logic  sel, grant;

  function automatic addr_t align_addr(addr_t addr, size_t size);
    addr_t mask;
    mask = (addr_t'(1) << size) - addr_t'(1);
    return addr & ~mask;
  endfunction

  assign r_ongoing = (r_cnt_q != '0);
  assign w_ongoing = (w_cnt_q != '0);

  // Candidate read beat.
  assign rd_valid = r_ongoing | ar_valid_i;
  assign rd_addr  = r_ongoing ? r_addr_q + (addr_t'(1) << r_size_q)
                              : align_addr(ar_addr_i, ar_size_i);
  assign rd_id    = r_ongoing ? r_id_q : ar_id_i;
  assign rd_qos   = r_ongoing ? r_qos_q : ar_qos_i;
  assign rd_last  = r_ongoing ? (r_cnt_q == len_t'(1)) : (ar_len_i == '0);

  // Candidate write beat, which always needs W data.
  assign wr_valid = w_valid_i & (w_ongoing | aw_valid_i);
  assign wr_addr  = w_ongoing ? w_addr_q + (addr_t'(1) << w_size_q)
                              : align_addr(aw_addr_i, aw_size_i);
  assign wr_id    = w_ongoing ? w_id_q : aw_id_i;
  assign wr_qos   = w_ongoing ? w_qos_q : aw_qos_i;
  assign wr_last  = w_ongoing ? (w_cnt_q == len_t'(1)) : (aw_len_i == '0);

  // Pick a side; sel high selects the write beat.
  always_comb begin
    sel = sel_q;
    if (!lock_q) begin
      if (wr_valid ^ rd_valid) begin
        sel = wr_valid;
      end else if (wr_valid && rd_valid) begin
        if (wr_qos != rd_qos) begin
          sel = (wr_qos > rd_qos);
        end else if (wr_last && !rd_last) begin
          sel = 1'b1;
        end else if (w_ongoing) begin
          sel = 1'b1;
        end else if (r_ongoing) begin
          sel = 1'b0;
        end else begin
          // Take turns.
          sel = ~sel_q;
        end
      end
    end
  end

  assign mem_req_o   = (sel ? wr_valid : rd_valid) & ~full_i;
  assign grant       = mem_req_o & mem_gnt_i;
  assign mem_addr_o  = sel ? wr_addr : rd_addr;
  assign mem_wdata_o = w_data_i;
  assign mem_strb_o  = sel ? w_strb_i : '0;
  assign mem_we_o    = sel;

  assign ar_ready_o  = grant & ~sel & ~r_ongoing;
  assign aw_ready_o  = grant & sel & ~w_ongoing;
  assign w_ready_o   = grant & sel;

  assign alloc_o       = grant;
  assign alloc_id_o    = sel ? wr_id : rd_id;
  assign alloc_last_o  = sel ? wr_last : rd_last;
  assign alloc_write_o = sel;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_cnt_q <= '0;
      w_cnt_q <= '0;
      sel_q   <= 1'b0;
      lock_q  <= 1'b0;
    end else begin
      // An offered beat stays selected until the memory grants it.
      lock_q <= mem_req_o & ~mem_gnt_i;
      if (mem_req_o) begin
        sel_q <= sel;
      end
      if (grant && !sel) begin
        r_cnt_q <= r_ongoing ? r_cnt_q - len_t'(1) : ar_len_i;
      end
      if (grant && sel) begin
        w_cnt_q <= w_ongoing ? w_cnt_q - len_t'(1) : aw_len_i;
      end
    end
  end

  // Burst attributes, captured with the first beat.
  always_ff @(posedge clk_i) begin
    if (grant && !sel) begin
      r_addr_q <= rd_addr;
      if (!r_ongoing) begin
        r_id_q   <= ar_id_i;
        r_size_q <= ar_size_i;
        r_qos_q  <= ar_qos_i;
      end
    end
    if (grant && sel) begin
      w_addr_q <= wr_addr;
      if (!w_ongoing) begin
        w_id_q   <= aw_id_i;
        w_size_q <= aw_size_i;
        w_qos_q  <= aw_qos_i;
      end
    end
  end

endmodule

// File: verilog/txn_buffer.sv
// ####################################################################
// Outstanding request buffer.
// Holds the metadata of every granted beat in order and pairs it with
// the memory response that arrives for it, after a variable delay.
// ####################################################################

`timescale 1ns/1ps

module txn_buffer import axi_mem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  alloc_i,
  input  id_t   alloc_id_i,
  input  logic  alloc_last_i,
  input  logic  alloc_write_i,
  output logic  full_o,
  input  logic  mem_rvalid_i,
  input  data_t mem_rdata_i,
  input  logic  mem_err_i,
  output logic  head_valid_o,
  output id_t   head_id_o,
  output logic  head_last_o,
  output logic  head_write_o,
  output data_t head_data_o,
  output logic  head_err_o,
  input  logic  pop_i
);

  id_t   id_mem    [BUF_DEPTH];
  logic  last_mem  [BUF_DEPTH];
  logic  write_mem [BUF_DEPTH];
  data_t data_mem  [BUF_DEPTH];
  logic  err_mem   [BUF_DEPTH];

  logic [PTR_W-1:0] alloc_ptr_q, fill_ptr_q, pop_ptr_q;
  // Entries allocated but not popped, and filled but not popped.
  logic [CNT_W-1:0] used_q, filled_q;

  assign full_o       = (used_q == CNT_W'(BUF_DEPTH));
  assign head_valid_o = (filled_q != '0);
  assign head_id_o    = id_mem[pop_ptr_q];
  assign head_last_o  = last_mem[pop_ptr_q];
  assign head_write_o = write_mem[pop_ptr_q];
  assign head_data_o  = data_mem[pop_ptr_q];
  assign head_err_o   = err_mem[pop_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      alloc_ptr_q <= '0;
      fill_ptr_q  <= '0;
      pop_ptr_q   <= '0;
      used_q      <= '0;
      filled_q    <= '0;
    end else begin
      if (alloc_i) begin
        alloc_ptr_q <= alloc_ptr_q + PTR_W'(1);
      end
      if (mem_rvalid_i) begin
        fill_ptr_q <= fill_ptr_q + PTR_W'(1);
      end
      if (pop_i) begin
        pop_ptr_q <= pop_ptr_q + PTR_W'(1);
      end
      used_q   <= used_q + CNT_W'(alloc_i) - CNT_W'(pop_i);
      filled_q <= filled_q + CNT_W'(mem_rvalid_i) - CNT_W'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      id_mem[alloc_ptr_q]    <= alloc_id_i;
      last_mem[alloc_ptr_q]  <= alloc_last_i;
      write_mem[alloc_ptr_q] <= alloc_write_i;
    end
    if (mem_rvalid_i) begin
      data_mem[fill_ptr_q] <= mem_rdata_i;
      err_mem[fill_ptr_q]  <= mem_err_i;
    end
  end

endmodule

// File: verilog/axi_resp_composer.sv
// ####################################################################
// AXI response composer.
// Turns filled buffer entries into R beats and B responses, and folds
// the errors of all beats of a write burst into its single B.
// ####################################################################

`timescale 1ns/1ps

module axi_resp_composer import axi_mem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  head_valid_i,
  input  id_t   head_id_i,
  input  logic  head_last_i,
  input  logic  head_write_i,
  input  data_t head_data_i,
  input  logic  head_err_i,
  output logic  pop_o,
  output logic  r_valid_o,
  output data_t r_data_o,
  output id_t   r_id_o,
  output resp_t r_resp_o,
  output logic  r_last_o,
  input  logic  r_ready_i,
  output logic  b_valid_o,
  output id_t   b_id_o,
  output resp_t b_resp_o,
  input  logic  b_ready_i
);

  // Sticky error of the write burst at the head.
  logic wr_err_q;
  logic drop;
  logic b_done;

  // Write beats before the last one leave no trace on the bus.
  assign drop      = head_valid_i & head_write_i & ~head_last_i;

  assign r_valid_o = head_valid_i & ~head_write_i;
  assign r_data_o  = head_data_i;
  assign r_id_o    = head_id_i;
  assign r_last_o  = head_last_i;
  assign r_resp_o  = head_err_i ? RESP_SLVERR : RESP_OKAY;

  assign b_valid_o = head_valid_i & head_write_i & head_last_i;
  assign b_id_o    = head_id_i;
  assign b_resp_o  = (wr_err_q | head_err_i) ? RESP_SLVERR : RESP_OKAY;
  assign b_done    = b_valid_o & b_ready_i;

  assign pop_o = drop | (r_valid_o & r_ready_i) | b_done;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_err_q <= 1'b0;
    end else if (b_done) begin
      wr_err_q <= 1'b0;
    end else if (drop) begin
      wr_err_q <= wr_err_q | head_err_i;
    end
  end

endmodule

// File: verilog/axi_to_mem.sv
// ####################################################################
// AXI4 slave to memory bridge.
// Converts AXI4 read and write bursts into single-word requests to one
// memory and returns the in-order memory responses as R and B.
// ####################################################################

`timescale 1ns/1ps

module axi_to_mem import axi_mem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  ar_valid_i,
  input  id_t   ar_id_i,
  input  addr_t ar_addr_i,
  input  len_t  ar_len_i,
  input  size_t ar_size_i,
  input  qos_t  ar_qos_i,
  output logic  ar_ready_o,
  input  logic  aw_valid_i,
  input  id_t   aw_id_i,
  input  addr_t aw_addr_i,
  input  len_t  aw_len_i,
  input  size_t aw_size_i,
  input  qos_t  aw_qos_i,
  output logic  aw_ready_o,
  input  logic  w_valid_i,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  output logic  w_ready_o,
  output logic  r_valid_o,
  output data_t r_data_o,
  output id_t   r_id_o,
  output resp_t r_resp_o,
  output logic  r_last_o,
  input  logic  r_ready_i,
  output logic  b_valid_o,
  output id_t   b_id_o,
  output resp_t b_resp_o,
  input  logic  b_ready_i,
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output strb_t mem_strb_o,
  output logic  mem_we_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  data_t mem_rdata_i,
  input  logic  mem_err_i
);

  logic  full;
  logic  alloc, alloc_last, alloc_write;
  id_t   alloc_id;
  logic  head_valid, head_last, head_write, head_err;
  id_t   head_id;
  data_t head_data;
  logic  pop;

  axi_burst_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ar_valid_i    (ar_valid_i),
    .ar_id_i       (ar_id_i),
    .ar_addr_i     (ar_addr_i),
    .ar_len_i      (ar_len_i),
    .ar_size_i     (ar_size_i),
    .ar_qos_i      (ar_qos_i),
    .ar_ready_o    (ar_ready_o),
    .aw_valid_i    (aw_valid_i),
    .aw_id_i       (aw_id_i),
    .aw_addr_i     (aw_addr_i),
    .aw_len_i      (aw_len_i),
    .aw_size_i     (aw_size_i),
    .aw_qos_i      (aw_qos_i),
    .aw_ready_o    (aw_ready_o),
    .w_valid_i     (w_valid_i),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_ready_o     (w_ready_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_strb_o    (mem_strb_o),
    .mem_we_o      (mem_we_o),
    .mem_gnt_i     (mem_gnt_i),
    .full_i        (full),
    .alloc_o       (alloc),
    .alloc_id_o    (alloc_id),
    .alloc_last_o  (alloc_last),
    .alloc_write_o (alloc_write)
  );

  txn_buffer u_buffer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .alloc_i       (alloc),
    .alloc_id_i    (alloc_id),
    .alloc_last_i  (alloc_last),
    .alloc_write_i (alloc_write),
    .full_o        (full),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_err_i     (mem_err_i),
    .head_valid_o  (head_valid),
    .head_id_o     (head_id),
    .head_last_o   (head_last),
    .head_write_o  (head_write),
    .head_data_o   (head_data),
    .head_err_o    (head_err),
    .pop_i         (pop)
  );

  axi_resp_composer u_composer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_valid_i (head_valid),
    .head_id_i    (head_id),
    .head_last_i  (head_last),
    .head_write_i (head_write),
    .head_data_i  (head_data),
    .head_err_i   (head_err),
    .pop_o        (pop),
    .r_valid_o    (r_valid_o),
    .r_data_o     (r_data_o),
    .r_id_o       (r_id_o),
    .r_resp_o     (r_resp_o),
    .r_last_o     (r_last_o),
    .r_ready_i    (r_ready_i),
    .b_valid_o    (b_valid_o),
    .b_id_o       (b_id_o),
    .b_resp_o     (b_resp_o),
    .b_ready_i    (b_ready_i)
  );

endmodule

// File: sim/tb_mem_model.sv
// ####################################################################
// Behavioral single-port memory for the AXI to memory testbench.
// Grants when gnt_en_i is high, answers in request order once
// resp_en_i allows it, and flags an error inside an address window.
// ####################################################################

`timescale 1ns/1ps

module tb_mem_model import axi_mem_pkg::*; #(
  parameter addr_t ERR_LO = '0,
  parameter addr_t ERR_HI = '0
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  gnt_en_i,
  input  logic  resp_en_i,
  input  logic  mem_req_i,
  input  addr_t mem_addr_i,
  input  data_t mem_wdata_i,
  input  strb_t mem_strb_i,
  input  logic  mem_we_i,
  output logic  mem_gnt_o,
  output logic  mem_rvalid_o,
  output data_t mem_rdata_o,
  output logic  mem_err_o
);

  localparam int WORDS = 2 ** (ADDR_W - 2);

  data_t mem [WORDS];
  // Pending responses as {err, data}, oldest first.
  logic [DATA_W:0] resp_q [$];
  logic hit_err;
  data_t merged;
  logic [ADDR_W-3:0] word;

  assign mem_gnt_o = gnt_en_i;
  assign hit_err   = (mem_addr_i >= ERR_LO) && (mem_addr_i <= ERR_HI);
  assign word      = mem_addr_i[ADDR_W-1:2];

  // Each word holds its own index twice, the second copy inverted.
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {2'b10, (ADDR_W-2)'(i), 2'b01, ~(ADDR_W-2)'(i)};
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      resp_q.delete();
      mem_rvalid_o <= 1'b0;
      mem_rdata_o  <= '0;
      mem_err_o    <= 1'b0;
    end else begin
      // Pop before push, so every response comes at least a cycle later.
      if (resp_en_i && resp_q.size() != 0) begin
        {mem_err_o, mem_rdata_o} <= resp_q.pop_front();
        mem_rvalid_o <= 1'b1;
      end else begin
        mem_rvalid_o <= 1'b0;
      end
      if (mem_req_i && mem_gnt_o) begin
        resp_q.push_back({hit_err, mem[word]});
        // Writes into the error window are dropped.
        if (mem_we_i && !hit_err) begin
          merged = mem[word];
          for (int b = 0; b < STRB_W; b++) begin
            if (mem_strb_i[b]) begin
              merged[8*b +: 8] = mem_wdata_i[8*b +: 8];
            end
          end
          mem[word] = merged;
        end
      end
    end
  end

endmodule

// File: sim/tb_axi_to_mem.sv
// ####################################################################
// Testbench for the AXI4 to memory bridge.
// Drives read and write bursts against a behavioral memory with random
// grant stalls, response delays and R/B back-pressure, and checks every
// R beat and B response against a scoreboard built from a memory mirror.
// ####################################################################

`timescale 1ns/1ps

module tb_axi_to_mem import axi_mem_pkg::*;;

  localparam int    WORDS  = 2 ** (ADDR_W - 2);
  localparam addr_t ERR_LO = 16'h0800;
  localparam addr_t ERR_HI = 16'h080F;

  logic  clk_i, rst_i;
  logic  ar_valid_i, aw_valid_i, w_valid_i, r_ready_i, b_ready_i;
  id_t   ar_id_i, aw_id_i;
  addr_t ar_addr_i, aw_addr_i;
  len_t  ar_len_i, aw_len_i;
  size_t ar_size_i, aw_size_i;
  qos_t  ar_qos_i, aw_qos_i;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  ar_ready_o, aw_ready_o, w_ready_o;
  logic  r_valid_o, r_last_o, b_valid_o;
  data_t r_data_o;
  id_t   r_id_o, b_id_o;
  resp_t r_resp_o, b_resp_o;
  logic  mem_req_o, mem_we_o, mem_gnt, mem_rvalid, mem_err;
  addr_t mem_addr_o;
  data_t mem_wdata_o, mem_rdata;
  strb_t mem_strb_o;
  logic  gnt_en, resp_en;

  logic [15:0] lfsr_q = 16'd1306;
  data_t mirror [WORDS];
  data_t wdata_buf [256];
  strb_t wstrb_buf [256];
  // Expected R beats as {data, id, resp, last} and B as {id, resp}.
  logic [DATA_W+ID_W+2:0] exp_r [$];
  logic [ID_W+1:0]        exp_b [$];
  logic [DATA_W+ID_W+2:0] r_exp;
  logic [ID_W+1:0]        b_exp;
  string test_name;
  int    issued_beats;
  int    inflight;

  axi_to_mem uut (
    .clk_i(clk_i), .rst_i(rst_i),
    .ar_valid_i(ar_valid_i), .ar_id_i(ar_id_i), .ar_addr_i(ar_addr_i),
    .ar_len_i(ar_len_i), .ar_size_i(ar_size_i), .ar_qos_i(ar_qos_i),
    .ar_ready_o(ar_ready_o),
    .aw_valid_i(aw_valid_i), .aw_id_i(aw_id_i), .aw_addr_i(aw_addr_i),
    .aw_len_i(aw_len_i), .aw_size_i(aw_size_i), .aw_qos_i(aw_qos_i),
    .aw_ready_o(aw_ready_o),
    .w_valid_i(w_valid_i), .w_data_i(w_data_i), .w_strb_i(w_strb_i),
    .w_ready_o(w_ready_o),
    .r_valid_o(r_valid_o), .r_data_o(r_data_o), .r_id_o(r_id_o),
    .r_resp_o(r_resp_o), .r_last_o(r_last_o), .r_ready_i(r_ready_i),
    .b_valid_o(b_valid_o), .b_id_o(b_id_o), .b_resp_o(b_resp_o),
    .b_ready_i(b_ready_i),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
    .mem_strb_o(mem_strb_o), .mem_we_o(mem_we_o), .mem_gnt_i(mem_gnt),
    .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata), .mem_err_i(mem_err)
  );

  tb_mem_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) u_mem (
    .clk_i(clk_i), .rst_i(rst_i), .gnt_en_i(gnt_en), .resp_en_i(resp_en),
    .mem_req_i(mem_req_o), .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o),
    .mem_strb_i(mem_strb_o), .mem_we_i(mem_we_o), .mem_gnt_o(mem_gnt),
    .mem_rvalid_o(mem_rvalid), .mem_rdata_o(mem_rdata), .mem_err_o(mem_err)
  );

  // Taps 16, 14, 13, 11.
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic addr_t beat_addr(addr_t addr, size_t size, int k);
    addr_t base;
    base = (addr >> size) << size;
    return base + addr_t'(k << size);
  endfunction

  function automatic logic in_window(addr_t a);
    return (a >= ERR_LO) && (a <= ERR_HI);
  endfunction

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_eq(string what, logic [31:0] exp, logic [31:0] act);
    assert (act == exp) else begin
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic queue_read(id_t id, addr_t addr, len_t len, size_t size);
    addr_t a;
    for (int k = 0; k <= int'(len); k++) begin
      a = beat_addr(addr, size, k);
      exp_r.push_back({mirror[a[ADDR_W-1:2]], id,
                       in_window(a) ? RESP_SLVERR : RESP_OKAY, k == int'(len)});
    end
    issued_beats += int'(len) + 1;
  endtask

  task automatic queue_write(id_t id, addr_t addr, len_t len, size_t size);
    addr_t a;
    logic  err;
    err = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      wdata_buf[k] = rand_bits(DATA_W);
      wstrb_buf[k] = strb_t'(rand_bits(STRB_W));
      a = beat_addr(addr, size, k);
      if (in_window(a)) begin
        err = 1'b1;
      end else begin
        for (int b = 0; b < STRB_W; b++) begin
          if (wstrb_buf[k][b]) begin
            mirror[a[ADDR_W-1:2]][8*b +: 8] = wdata_buf[k][8*b +: 8];
          end
        end
      end
    end
    exp_b.push_back({id, err ? RESP_SLVERR : RESP_OKAY});
    issued_beats += int'(len) + 1;
  endtask

  task automatic drive_read(id_t id, addr_t addr, len_t len, size_t size, qos_t qos);
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = addr;
    ar_len_i   = len;
    ar_size_i  = size;
    ar_qos_i   = qos;
    @(negedge clk_i);
    while (!ar_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b0;
  endtask

  task automatic drive_write(id_t id, addr_t addr, len_t len, size_t size, qos_t qos);
    @(posedge clk_i);
    #1;
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = len;
    aw_size_i  = size;
    aw_qos_i   = qos;
    for (int i = 0; i <= int'(len); i++) begin
      w_valid_i = 1'b1;
      w_data_i  = wdata_buf[i];
      w_strb_i  = wstrb_buf[i];
      @(negedge clk_i);
      while (!w_ready_o) @(negedge clk_i);
      check_eq("aw_ready with W beat", 32'(i == 0), 32'(aw_ready_o));
      @(posedge clk_i);
      #1;
      aw_valid_i = 1'b0;
    end
    w_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_r.size() != 0 || exp_b.size() != 0) @(negedge clk_i);
  endtask

  // Stimulus draws happen at a falling edge, away from the knob process.
  task automatic run_read(string name, id_t id, addr_t addr, len_t len, size_t size);
    test_name = name;
    @(negedge clk_i);
    queue_read(id, addr, len, size);
    drive_read(id, addr, len, size, '0);
    wait_idle();
  endtask

  task automatic run_write(string name, id_t id, addr_t addr, len_t len, size_t size);
    test_name = name;
    @(negedge clk_i);
    queue_write(id, addr, len, size);
    drive_write(id, addr, len, size, '0);
    wait_idle();
  endtask

  task automatic run_pair(string name, id_t rid, addr_t raddr, len_t rlen, qos_t rqos,
                          id_t wid, addr_t waddr, len_t wlen, qos_t wqos, logic exp_we);
    test_name = name;
    @(negedge clk_i);
    queue_read(rid, raddr, rlen, 3'd2);
    queue_write(wid, waddr, wlen, 3'd2);
    fork
      drive_read(rid, raddr, rlen, 3'd2, rqos);
      drive_write(wid, waddr, wlen, 3'd2, wqos);
      begin
        @(negedge clk_i);
        while (!mem_req_o) @(negedge clk_i);
        check_eq("first mem_we", 32'(exp_we), 32'(mem_we_o));
        check_eq("first mem_addr", 32'(exp_we ? waddr : raddr), 32'(mem_addr_o));
      end
    join
    wait_idle();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Back-pressure, grant stalls and response delays.
  initial begin
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    gnt_en    = 1'b0;
    resp_en   = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      r_ready_i = lfsr_bit();
      b_ready_i = lfsr_bit();
      gnt_en    = lfsr_bit() | lfsr_bit();
      resp_en   = lfsr_bit();
    end
  end

  always @(negedge clk_i) begin
    if (!rst_i && r_valid_o && r_ready_i) begin
      if (exp_r.size() == 0) begin
        $display("Unexpected R beat with id %0h in %s", r_id_o, test_name);
        abort_run();
      end
      r_exp = exp_r.pop_front();
      check_eq("R data", r_exp[DATA_W+ID_W+2:ID_W+3], r_data_o);
      check_eq("R id", 32'(r_exp[ID_W+2:3]), 32'(r_id_o));
      check_eq("R resp", 32'(r_exp[2:1]), 32'(r_resp_o));
      check_eq("R last", 32'(r_exp[0]), 32'(r_last_o));
    end
    if (!rst_i && b_valid_o && b_ready_i) begin
      if (exp_b.size() == 0) begin
        $display("Unexpected B response with id %0h in %s", b_id_o, test_name);
        abort_run();
      end
      b_exp = exp_b.pop_front();
      check_eq("B id", 32'(b_exp[ID_W+1:2]), 32'(b_id_o));
      check_eq("B resp", 32'(b_exp[1:0]), 32'(b_resp_o));
    end
  end

  // Granted requests still waiting for their memory response.
  always @(negedge clk_i) begin
    if (rst_i) begin
      inflight = 0;
    end else begin
      inflight = inflight + ((mem_req_o && mem_gnt) ? 1 : 0) - (mem_rvalid ? 1 : 0);
      assert (inflight <= BUF_DEPTH) else begin
        $display("More than %0d memory requests in flight in %s", BUF_DEPTH, test_name);
        abort_run();
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > 200 * (issued_beats + 1)) begin
        $display("Timeout after %0d cycles with %0d beats issued", cycles, issued_beats);
        abort_run();
      end
    end
  end

  initial begin
    rst_i        = 1'b1;
    ar_valid_i   = 1'b0;
    aw_valid_i   = 1'b0;
    w_valid_i    = 1'b0;
    ar_id_i      = '0;
    ar_addr_i    = '0;
    ar_len_i     = '0;
    ar_size_i    = '0;
    ar_qos_i     = '0;
    aw_id_i      = '0;
    aw_addr_i    = '0;
    aw_len_i     = '0;
    aw_size_i    = '0;
    aw_qos_i     = '0;
    w_data_i     = '0;
    w_strb_i     = '0;
    issued_beats = 0;
    test_name    = "reset";
    for (int i = 0; i < WORDS; i++) begin
      mirror[i] = {2'b10, (ADDR_W-2)'(i), 2'b01, ~(ADDR_W-2)'(i)};
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    repeat (10) begin
      @(negedge clk_i);
      check_eq("idle outputs", 32'd0, 32'({ar_ready_o, aw_ready_o, w_ready_o,
                                           r_valid_o, b_valid_o, mem_req_o}));
    end
    run_read("read_word", 4'h1, 16'h0103, 8'd7, 3'd2);
    run_read("read_half", 4'h2, 16'h0206, 8'd3, 3'd1);
    run_write("write_strobes", 4'h3, 16'h0400, 8'd5, 3'd2);
    run_read("read_back", 4'h4, 16'h0400, 8'd5, 3'd2);
    run_read("read_err_window", 4'h5, 16'h07F8, 8'd7, 3'd2);
    run_write("write_err_window", 4'h6, 16'h0808, 8'd3, 3'd2);
    run_write("write_err_last", 4'h8, 16'h07F8, 8'd2, 3'd2);
    run_write("write_short", 4'h7, 16'h0600, 8'd1, 3'd2);
    for (int n = 0; n < 4; n++) begin
      run_write("stress_write", id_t'(n + 8), addr_t'(16'h1000 + n * 16'h100), 8'd15, 3'd2);
      run_read("stress_read", id_t'(n + 12), addr_t'(16'h1000 + n * 16'h100), 8'd15, 3'd2);
    end
    run_pair("arb_qos_write", 4'h9, 16'h0A00, 8'd3, 4'd2, 4'hA, 16'h0B00, 8'd2, 4'd5, 1'b1);
    run_pair("arb_qos_read", 4'hB, 16'h0C00, 8'd2, 4'd7, 4'hC, 16'h0D00, 8'd3, 4'd3, 1'b0);
    run_pair("arb_single_write", 4'hD, 16'h0E00, 8'd3, 4'd4, 4'hE, 16'h0F00, 8'd0, 4'd4,
             1'b1);
    if (exp_r.size() == 0 && exp_b.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Responses still pending at the end of the run");
      abort_run();
    end
  end

endmodule

// File: filelist.f
verilog/axi_mem_pkg.sv
verilog/axi_burst_sequencer.sv
verilog/txn_buffer.sv
verilog/axi_resp_composer.sv
verilog/axi_to_mem.sv
sim/tb_mem_model.sv
sim/tb_axi_to_mem.sv

// File: Makefile
TOP := tb_axi_to_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f verilog/*.sv sim/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
